// ==== all.f ====
+incdir+rtl
rtl/wideAddPkg.sv
rtl/brentKungAdder16.sv
rtl/operandShifter.sv
rtl/resultCollector.sv
rtl/arithCtrl.sv
rtl/wideAddTop.sv
verif/wideAddTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass message in the log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module wideAddTb -o simv \
    > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1 ;
cat sim.log 2>/dev/null ;
grep -q "Test OK" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verif/wideAddTb.sv ====
`timescale 1ns/100ps
`include "wideadd_macros.svh"

module wideAddTb
    import wideAddPkg::*;
();

    localparam int MAX_CYCLES = 1000;
    localparam logic [`DATA_WIDTH-1:0] ALL_ONES = '1;
    localparam logic [`DATA_WIDTH-1:0] MOST_NEG = {1'b1, {(`DATA_WIDTH-1){1'b0}}};
    localparam logic [`DATA_WIDTH-1:0] MOST_POS = ~MOST_NEG;
    localparam logic [`DATA_WIDTH-1:0] ONE = 1;

    logic        clk;
    logic        rstN;
    logic        inValid;
    logic        inReady;
    addReq_t     inReq;
    logic        outValid;
    logic        outReady;
    addRsp_t     outRsp;
    addRsp_t     expRsp;
    logic [63:0] lcgState;
    int          errors;
    int          txCount;
    int          cycles;

    wideAddTop UUT (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inReq    (inReq),
        .outValid (outValid),
        .outReady (outReady),
        .outRsp   (outRsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    function logic [63:0] nextRand();
        lcgState = lcgState * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcgState;
    endfunction

    // Reference result from the arithmetic definition of add and subtract
    function automatic addRsp_t modelRsp(input addReq_t r);
        logic signed [`DATA_WIDTH+1:0] wide;
        logic        [`DATA_WIDTH:0]   full;
        addRsp_t                       m;
        if (r.op == OP_ADD) begin
            full       = {1'b0, r.a} + {1'b0, r.b};
            wide       = $signed({{2{r.a[`DATA_WIDTH-1]}}, r.a})
                       + $signed({{2{r.b[`DATA_WIDTH-1]}}, r.b});
            m.carryOut = full[`DATA_WIDTH];
        end else begin
            wide       = $signed({{2{r.a[`DATA_WIDTH-1]}}, r.a})
                       - $signed({{2{r.b[`DATA_WIDTH-1]}}, r.b});
            m.carryOut = (r.a >= r.b);
        end
        m.sum      = wide[`DATA_WIDTH-1:0];
        // Signed result out of range when the top two bits disagree
        m.overflow = (wide[`DATA_WIDTH] != wide[`DATA_WIDTH-1]);
        m.zero     = (m.sum == '0);
        return m;
    endfunction

    resultMatch: assert property (@(posedge clk) disable iff (!rstN)
        outValid && outReady |-> outRsp == expRsp)
        else begin
            errors++;
            $display("** Error at %0t: outRsp = %h, expected %h", $time, outRsp, expRsp);
        end

    latencyFour: assert property (@(posedge clk) disable iff (!rstN)
        $rose(outValid) |-> $past(inValid && inReady, 5))
        else begin
            errors++;
            $display("outValid at %0t did not rise 4 cycles after acceptance", $time);
        end

    holdUnderStall: assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(outRsp))
        else begin
            errors++;
            $display("Result dropped or changed at %0t while outReady was low", $time);
        end

    busyAfterAccept: assert property (@(posedge clk) disable iff (!rstN)
        inValid && inReady |=> !inReady)
        else begin
            errors++;
            $display("inReady still high at %0t right after an acceptance", $time);
        end

    busyUntilTransfer: assert property (@(posedge clk) disable iff (!rstN)
        !inReady && !(outValid && outReady) |=> !inReady)
        else begin
            errors++;
            $display("inReady rose at %0t before the result was taken", $time);
        end

    task automatic checkIdleOutputs();
        assert (outValid === 1'b0) else begin
            errors++;
            $display("** Error at %0t: outValid = %b, expected 0", $time, outValid);
        end
        assert (inReady === 1'b1) else begin
            errors++;
            $display("** Error at %0t: inReady = %b, expected 1", $time, inReady);
        end
    endtask

    task automatic runOp(input arithOp_e op, input logic [`DATA_WIDTH-1:0] a,
                         input logic [`DATA_WIDTH-1:0] b, input int holdCycles);
        inReq.op = op;
        inReq.a  = a;
        inReq.b  = b;
        expRsp   = modelRsp(inReq);
        inValid  = 1'b1;
        outReady = (holdCycles == 0);
        while (!inReady) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        // The request stays offered during a stall and must not be taken
        inValid = (holdCycles != 0);
        while (!outValid) begin
            @(posedge clk);
            #2;
        end
        repeat (holdCycles) begin
            @(posedge clk);
            #2;
        end
        outReady = 1'b1;
        @(posedge clk);
        #2;
        inValid  = 1'b0;
        outReady = 1'b0;
        txCount++;
    endtask

    initial begin
        logic [63:0] r;
        errors   = 0;
        txCount  = 0;
        cycles   = 0;
        lcgState = 64'd52;
        rstN     = 1'b0;
        inValid  = 1'b0;
        outReady = 1'b0;
        inReq    = '0;
        expRsp   = '0;
        #1;
        checkIdleOutputs();
        repeat (2) @(posedge clk);
        #2;
        checkIdleOutputs();
        rstN = 1'b1;
        @(posedge clk);
        #2;
        checkIdleOutputs();

        runOp(OP_ADD, ALL_ONES, ONE, 0);
        runOp(OP_ADD, '0, '0, 0);
        runOp(OP_ADD, MOST_POS, ONE, 2);
        runOp(OP_ADD, MOST_NEG, MOST_NEG, 0);
        runOp(OP_SUB, MOST_NEG, ONE, 0);
        runOp(OP_SUB, 64'h0123_4567_89ab_cdef, 64'h0123_4567_89ab_cdef, 3);
        runOp(OP_SUB, '0, ONE, 0);
        runOp(OP_SUB, '0, MOST_NEG, 1);
        runOp(OP_SUB, ALL_ONES, ALL_ONES, 0);
        runOp(OP_ADD, ALL_ONES, ALL_ONES, 0);

        repeat (30) begin
            r = nextRand();
            runOp(arithOp_e'(r[63]), nextRand(), nextRand(), int'(nextRand() >> 61) % 6);
        end

        @(posedge clk);
        #2;
        $display("Transactions: %0d, errors: %0d", txCount, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/wideAddTop.sv ====
`timescale 1ns/100ps
`include "wideadd_macros.svh"

module wideAddTop
    import wideAddPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    output logic    inReady,
    input  addReq_t inReq,
    output logic    outValid,
    input  logic    outReady,
    output addRsp_t outRsp
);

    logic                    load;
    logic                    step;
    logic                    lastSlice;
    logic [`SLICE_WIDTH-1:0] aSlice;
    logic [`SLICE_WIDTH-1:0] bSlice;
    logic [`SLICE_WIDTH-1:0] sliceSum;
    logic                    sliceCarry;
    logic                    carryIn;

    arithCtrl ctrl (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .outReady  (outReady),
        .inReady   (inReady),
        .outValid  (outValid),
        .load      (load),
        .step      (step),
        .lastSlice (lastSlice)
    );

    operandShifter shifter (
        .clk    (clk),
        .rstN   (rstN),
        .load   (load),
        .step   (step),
        .req    (inReq),
        .aSlice (aSlice),
        .bSlice (bSlice)
    );

    // One adder reused for every slice
    brentKungAdder16 adder (
        .a        (aSlice),
        .b        (bSlice),
        .carryIn  (carryIn),
        .sum      (sliceSum),
        .carryOut (sliceCarry)
    );

    // op is only sampled with load, while inReq is still held by the source
    resultCollector collector (
        .clk        (clk),
        .rstN       (rstN),
        .load       (load),
        .step       (step),
        .lastSlice  (lastSlice),
        .op         (inReq.op),
        .sliceSum   (sliceSum),
        .sliceCarry (sliceCarry),
        .aSlice     (aSlice),
        .bSlice     (bSlice),
        .carryIn    (carryIn),
        .rsp        (outRsp)
    );

endmodule

// ==== rtl/arithCtrl.sv ====
`timescale 1ns/100ps
`include "wideadd_macros.svh"

module arithCtrl
    import wideAddPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    input  logic outReady,
    output logic inReady,
    output logic outValid,
    output logic load,
    output logic step,
    output logic lastSlice
);

    localparam int CNT_WIDTH = $clog2(`SLICE_COUNT);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_DONE
    } ctrlState_e;

    ctrlState_e           state;
    logic [CNT_WIDTH-1:0] sliceCnt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= ST_IDLE;
            sliceCnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    sliceCnt <= '0;
                    if (inValid) begin
                        state <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    sliceCnt <= sliceCnt + 1'b1;
                    if (lastSlice) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    // Result holds here until the consumer takes it
                    if (outReady) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign inReady   = (state == ST_IDLE);
    assign load      = inReady & inValid;
    assign step      = (state == ST_BUSY);
    assign lastSlice = step && (sliceCnt == CNT_WIDTH'(`SLICE_COUNT - 1));
    assign outValid  = (state == ST_DONE);

endmodule

// ==== rtl/resultCollector.sv ====
`timescale 1ns/100ps
`include "wideadd_macros.svh"

module resultCollector
    import wideAddPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    load,
    input  logic                    step,
    input  logic                    lastSlice,
    input  arithOp_e                op,
    input  logic [`SLICE_WIDTH-1:0] sliceSum,
    input  logic                    sliceCarry,
    input  logic [`SLICE_WIDTH-1:0] aSlice,
    input  logic [`SLICE_WIDTH-1:0] bSlice,
    output logic                    carryIn,
    output addRsp_t                 rsp
);

    logic    carryReg;
    logic    nonZero;
    addRsp_t rspReg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            carryReg <= 1'b0;
            nonZero  <= 1'b0;
            rspReg   <= '0;
        end else if (load) begin
            carryReg <= (op == OP_SUB);
            nonZero  <= 1'b0;
        end else if (step) begin
            carryReg    <= sliceCarry;
            nonZero     <= nonZero | (|sliceSum);
            // Slices enter at the top so slice 0 sits at the bottom after the last step
            rspReg.sum  <= {sliceSum, rspReg.sum[`DATA_WIDTH-1:`SLICE_WIDTH]};
            if (lastSlice) begin
                rspReg.carryOut <= sliceCarry;
                rspReg.overflow <= (aSlice[`SLICE_WIDTH-1] == bSlice[`SLICE_WIDTH-1]) &&
                                   (sliceSum[`SLICE_WIDTH-1] != aSlice[`SLICE_WIDTH-1]);
                rspReg.zero     <= ~(nonZero | (|sliceSum));
            end
        end
    end

    assign carryIn = carryReg;
    assign rsp     = rspReg;

endmodule

// ==== rtl/operandShifter.sv ====
`timescale 1ns/100ps
`include "wideadd_macros.svh"

module operandShifter
    import wideAddPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    load,
    input  logic                    step,
    input  addReq_t                 req,
    output logic [`SLICE_WIDTH-1:0] aSlice,
    output logic [`SLICE_WIDTH-1:0] bSlice
);

    logic [`DATA_WIDTH-1:0] aReg;
    logic [`DATA_WIDTH-1:0] bReg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aReg <= '0;
            bReg <= '0;
        end else if (load) begin
            aReg <= req.a;
            // Subtract adds the complement and takes the +1 as carry in
            bReg <= (req.op == OP_SUB) ? ~req.b : req.b;
        end else if (step) begin
            aReg <= aReg >> `SLICE_WIDTH;
            bReg <= bReg >> `SLICE_WIDTH;
        end
    end

    // Least significant slice goes first
    assign aSlice = aReg[`SLICE_WIDTH-1:0];
    assign bSlice = bReg[`SLICE_WIDTH-1:0];

endmodule

// ==== rtl/brentKungAdder16.sv ====
`timescale 1ns/100ps

module brentKungAdder16 (
    input  logic [15:0] a,
    input  logic [15:0] b,
    input  logic        carryIn,
    output logic [15:0] sum,
    output logic        carryOut
);

    // Generate and propagate of a single bit or of a bit group
    typedef struct packed {
        logic g;
        logic p;
    } genProp_t;

    genProp_t [15:0] bitGp;
    genProp_t [7:0]  up1;
    genProp_t [3:0]  up2;
    genProp_t [1:0]  up3;
    genProp_t        up4;
    genProp_t        dn5;
    genProp_t [2:0]  dn6;
    genProp_t [6:0]  dn7;
    genProp_t [15:0] prefix;
    logic     [15:0] carry;

    // Merge a high group with the adjacent lower group
    function automatic genProp_t dot(input genProp_t hi, input genProp_t lo);
        genProp_t res;
        res.g = hi.g | (hi.p & lo.g);
        res.p = hi.p & lo.p;
        return res;
    endfunction

    for (genvar i = 0; i < 16; i++) begin : gBit
        assign bitGp[i].g = a[i] & b[i];
        assign bitGp[i].p = a[i] | b[i];
    end

    // Up-sweep builds groups of 2, 4, 8 and 16 bits
    for (genvar k = 0; k < 8; k++) begin : gUp1
        assign up1[k] = dot(bitGp[2*k+1], bitGp[2*k]);
    end

    for (genvar k = 0; k < 4; k++) begin : gUp2
        assign up2[k] = dot(up1[2*k+1], up1[2*k]);
    end

    for (genvar k = 0; k < 2; k++) begin : gUp3
        assign up3[k] = dot(up2[2*k+1], up2[2*k]);
    end

    assign up4 = dot(up3[1], up3[0]);

    // Down-sweep fills in the remaining prefixes from bit 0
    // bits 11:0
    assign dn5 = dot(up2[2], up3[0]);

    // bits 5:0, 9:0 and 13:0
    assign dn6[0] = dot(up1[2], up2[0]);
    assign dn6[1] = dot(up1[4], up3[0]);
    assign dn6[2] = dot(up1[6], dn5);

    // Even positions 2 to 14
    assign dn7[0] = dot(bitGp[2], up1[0]);
    assign dn7[1] = dot(bitGp[4], up2[0]);
    assign dn7[2] = dot(bitGp[6], dn6[0]);
    assign dn7[3] = dot(bitGp[8], up3[0]);
    assign dn7[4] = dot(bitGp[10], dn6[1]);
    assign dn7[5] = dot(bitGp[12], dn5);
    assign dn7[6] = dot(bitGp[14], dn6[2]);

    // prefix[i] covers bits i down to 0
    assign prefix = {
        up4,
        dn7[6],
        dn6[2],
        dn7[5],
        dn5,
        dn7[4],
        dn6[1],
        dn7[3],
        up3[0],
        dn7[2],
        dn6[0],
        dn7[1],
        up2[0],
        dn7[0],
        up1[0],
        bitGp[0]
    };

    // Carry-in passes through wherever the whole group propagates
    for (genvar i = 0; i < 16; i++) begin : gCarry
        assign carry[i] = prefix[i].g | (prefix[i].p & carryIn);
    end

    assign sum      = a ^ b ^ {carry[14:0], carryIn};
    assign carryOut = carry[15];

endmodule

// ==== rtl/wideAddPkg.sv ====
`include "wideadd_macros.svh"

package wideAddPkg;

    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } arithOp_e;

    typedef struct packed {
        arithOp_e                op;
        logic [`DATA_WIDTH-1:0]  a;
        logic [`DATA_WIDTH-1:0]  b;
    } addReq_t;

    // For subtract, carryOut set means no borrow
    typedef struct packed {
        logic [`DATA_WIDTH-1:0]  sum;
        logic                    carryOut;
        logic                    overflow;
        logic                    zero;
    } addRsp_t;

endpackage

// ==== rtl/wideadd_macros.svh ====
`ifndef WIDEADD_MACROS_SVH
`define WIDEADD_MACROS_SVH

// Operand width may be any multiple of the slice width
`define DATA_WIDTH 64

// Fixed by the 16-bit prefix adder
`define SLICE_WIDTH 16

`define SLICE_COUNT (`DATA_WIDTH / `SLICE_WIDTH)

`endif
